// File: ram_dgd_monitor.sv
// RAM data-integrity monitor, top level
// Tracks frame CRCs on the RAM write and read streams side by side and
// reports a degradation error after repeated mismatches

`timescale 1ns/10ps
`default_nettype none

module ram_dgd_monitor (
    input  logic                clk_wr,
    input  logic                rst_wr_n,
    input  rdg_pkg::word_beat_t wr_beat,
    input  rdg_pkg::word_beat_t rd_beat,
    input  logic                slink_prd_err,
    output rdg_pkg::err_cnt_t   dgd_err_cnt,
    output logic                ram_dgd_err
);

    rdg_pkg::crc_result_t wr_result;
    rdg_pkg::crc_result_t rd_result;

    // ------------------------------------------------------------------------
    // Frame CRC trackers
    // ------------------------------------------------------------------------
    // Words going into the RAM
    rdg_frame_crc u_wr_crc (
        .clk_wr   (clk_wr),
        .rst_wr_n (rst_wr_n),
        .beat     (wr_beat),
        .result   (wr_result)
    );

    // Same frame coming back out
    rdg_frame_crc u_rd_crc (
        .clk_wr   (clk_wr),
        .rst_wr_n (rst_wr_n),
        .beat     (rd_beat),
        .result   (rd_result)
    );

    // ------------------------------------------------------------------------
    // Mismatch judgement
    // ------------------------------------------------------------------------
    rdg_err_judge u_judge (
        .clk_wr        (clk_wr),
        .rst_wr_n      (rst_wr_n),
        .wr_result     (wr_result),
        .rd_result     (rd_result),
        .slink_prd_err (slink_prd_err),
        .dgd_err_cnt   (dgd_err_cnt),
        .ram_dgd_err   (ram_dgd_err)
    );

endmodule

`default_nettype wire

// File: rdg_defines.svh
// RAM degradation monitor constants
// Word and CRC widths, CRC window length and the mismatch limit

`ifndef RDG_DEFINES_SVH
`define RDG_DEFINES_SVH

// ---------------------------------------------------------------------------
// Data path
// ---------------------------------------------------------------------------
`define RDG_DATA_W      16

// ---------------------------------------------------------------------------
// CRC-16/CCITT engine
// ---------------------------------------------------------------------------
`define RDG_CRC_W       16
`define RDG_CRC_POLY    16'h1021
`define RDG_CRC_SEED    16'hFFFF

// Valid words per frame that go into the CRC, and the index width to count them
`define RDG_CRC_WORDS   56
`define RDG_IDX_W       6

// ---------------------------------------------------------------------------
// Error judgement
// ---------------------------------------------------------------------------
`define RDG_ERR_LIMIT   5

`endif

// File: rdg_err_judge.sv
// Degradation error judge
// Holds the write-side frame CRC, compares each read-side CRC with it,
// counts mismatches outside link error periods and flags degradation

`timescale 1ns/10ps
`default_nettype none

`include "rdg_defines.svh"

module rdg_err_judge (
    input  logic                 clk_wr,
    input  logic                 rst_wr_n,
    input  rdg_pkg::crc_result_t wr_result,
    input  rdg_pkg::crc_result_t rd_result,
    input  logic                 slink_prd_err,
    output rdg_pkg::err_cnt_t    dgd_err_cnt,
    output logic                 ram_dgd_err
);

    localparam rdg_pkg::err_cnt_t ERR_LIMIT = rdg_pkg::err_cnt_t'(`RDG_ERR_LIMIT);

    rdg_pkg::crc16_t crc_held;
    logic            crc_diff;
    logic            cnt_inc;

    // ------------------------------------------------------------------------
    // Write-side reference
    // ------------------------------------------------------------------------
    // Only replaced when a new write frame completes
    always_ff @(posedge clk_wr) begin
        if (wr_result.done) begin
            crc_held <= wr_result.crc;
        end
    end

    // ------------------------------------------------------------------------
    // Compare and count
    // ------------------------------------------------------------------------
    // Held value is the one from before this edge
    assign crc_diff = rd_result.done && (rd_result.crc != crc_held);

    // Mismatches during a link period error are not the RAM's fault
    assign cnt_inc  = crc_diff && !slink_prd_err && (dgd_err_cnt != ERR_LIMIT);

    always_ff @(posedge clk_wr or negedge rst_wr_n) begin
        if (!rst_wr_n) begin
            dgd_err_cnt <= '0;
        end else if (cnt_inc) begin
            dgd_err_cnt <= dgd_err_cnt + 1'b1;
        end
    end

    // Sticky until reset
    always_ff @(posedge clk_wr or negedge rst_wr_n) begin
        if (!rst_wr_n) begin
            ram_dgd_err <= 1'b0;
        end else if (dgd_err_cnt == ERR_LIMIT) begin
            ram_dgd_err <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: rdg_frame_crc.sv
// Frame CRC tracker
// Runs CRC-16 over the first RDG_CRC_WORDS valid words after each sop
// and pulses done with the result once the window is complete

`timescale 1ns/10ps
`default_nettype none

`include "rdg_defines.svh"

module rdg_frame_crc (
    input  logic                 clk_wr,
    input  logic                 rst_wr_n,
    input  rdg_pkg::word_beat_t  beat,
    output rdg_pkg::crc_result_t result
);

    localparam rdg_pkg::word_idx_t LAST_IDX = rdg_pkg::word_idx_t'(`RDG_CRC_WORDS - 1);

    rdg_pkg::frame_state_e state;
    rdg_pkg::word_idx_t    word_idx;
    rdg_pkg::crc16_t       crc_run;

    logic                  absorb;
    logic                  last_word;
    rdg_pkg::word_idx_t    cur_idx;
    rdg_pkg::crc16_t       crc_base;
    rdg_pkg::crc16_t       crc_nxt;

    logic                  done_q;
    rdg_pkg::crc16_t       crc_q;

    // ------------------------------------------------------------------------
    // Word absorb
    // ------------------------------------------------------------------------
    // A sop restarts the window in any state, even mid-frame
    always_comb begin
        absorb    = beat.val && (beat.sop || state == rdg_pkg::ACCUM);
        cur_idx   = beat.sop ? '0 : word_idx;
        crc_base  = beat.sop ? `RDG_CRC_SEED : crc_run;
        crc_nxt   = rdg_pkg::crc16_next(crc_base, beat.data);
        last_word = absorb && (cur_idx == LAST_IDX);
    end

    // ------------------------------------------------------------------------
    // Window control
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_wr or negedge rst_wr_n) begin
        if (!rst_wr_n) begin
            state    <= rdg_pkg::IDLE;
            word_idx <= '0;
            done_q   <= 1'b0;
        end else begin
            done_q <= last_word;
            if (absorb) begin
                if (last_word) begin
                    // Words past the window are ignored until the next sop
                    state    <= rdg_pkg::IDLE;
                    word_idx <= '0;
                end else begin
                    state    <= rdg_pkg::ACCUM;
                    word_idx <= cur_idx + 1'b1;
                end
            end
        end
    end

    // Running CRC and captured frame result
    always_ff @(posedge clk_wr) begin
        if (absorb) begin
            crc_run <= crc_nxt;
        end
        if (last_word) begin
            crc_q <= crc_nxt;
        end
    end

    assign result = '{done: done_q, crc: crc_q};

endmodule

`default_nettype wire

// File: rdg_pkg.sv
// RAM degradation monitor types
// Word, CRC and counter types, tracker states, beat and result structs,
// and the word-wide CRC-16 update

`default_nettype none

`include "rdg_defines.svh"

package rdg_pkg;

    typedef logic [`RDG_DATA_W-1:0] data_word_t;
    typedef logic [`RDG_CRC_W-1:0]  crc16_t;
    typedef logic [`RDG_IDX_W-1:0]  word_idx_t;
    // Saturates at RDG_ERR_LIMIT
    typedef logic [2:0]             err_cnt_t;

    typedef enum logic [0:0] {
        IDLE  = 1'b0,
        ACCUM = 1'b1
    } frame_state_e;

    // One RAM word as seen on the write or read port
    typedef struct packed {
        logic       sop;
        logic       val;
        data_word_t data;
    } word_beat_t;

    // Frame CRC, qualified by a one-cycle done
    typedef struct packed {
        logic   done;
        crc16_t crc;
    } crc_result_t;

    // CRC-16/CCITT over one word, MSB first, no final inversion
    function automatic crc16_t crc16_next(input crc16_t crc_in, input data_word_t data);
        crc16_t crc;
        logic   fb;
        crc = crc_in;
        for (int i = `RDG_DATA_W - 1; i >= 0; i--) begin
            fb  = crc[`RDG_CRC_W-1] ^ data[i];
            crc = {crc[`RDG_CRC_W-2:0], 1'b0};
            if (fb) begin
                crc = crc ^ `RDG_CRC_POLY;
            end
        end
        return crc;
    endfunction

endpackage

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the RAM degradation monitor testbench with Verilator.
# Exit status is zero only when the log holds the pass message.

cd "$(dirname "$0")" || exit 1

TOP=tb_ram_dgd
BUILD_DIR=obj_dir
LOG=sim.log
PASS_MSG="Finished with no errors"

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

rm -rf "$BUILD_DIR" "$LOG"

verilator --binary --timing -j 0 \
    --top-module "$TOP" \
    -Mdir "$BUILD_DIR" \
    -f src.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "$PASS_MSG" "$LOG"; then
    echo "RESULT: PASS"
    exit 0
else
    echo "RESULT: FAIL"
    exit 1
fi

// File: src.f
+incdir+.
rdg_pkg.sv
rdg_frame_crc.sv
rdg_err_judge.sv
ram_dgd_monitor.sv
tb_ram_dgd_checker.sv
tb_ram_dgd.sv

// File: tb_ram_dgd.sv
// Testbench for the RAM data-integrity monitor
// Writes frames, reads them back clean or corrupted and lets the checker
// compare the mismatch count and the degradation flag

`timescale 1ns/10ps
`default_nettype none

`include "rdg_defines.svh"

module tb_ram_dgd;

    localparam int SEED         = 29605;
    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_FRAMES   = 16;
    localparam int GAP_CYCLES   = 20;
    localparam int WDOG_CYCLES  = NUM_FRAMES * (2 * 70 + GAP_CYCLES) * 4;

    logic                clk_wr;
    logic                rst_wr_n;
    rdg_pkg::word_beat_t wr_beat;
    rdg_pkg::word_beat_t rd_beat;
    logic                slink_prd_err;
    rdg_pkg::err_cnt_t   dgd_err_cnt;
    logic                ram_dgd_err;

    int                  checker_errors;
    int                  checks_done;
    int                  tb_errors   = 0;
    int                  frames_read = 0;

    rdg_pkg::data_word_t frame_words[$];
    rdg_pkg::data_word_t read_words[$];
    bit                  frame_sops[$];

    ram_dgd_monitor UUT (
        .clk_wr        (clk_wr),
        .rst_wr_n      (rst_wr_n),
        .wr_beat       (wr_beat),
        .rd_beat       (rd_beat),
        .slink_prd_err (slink_prd_err),
        .dgd_err_cnt   (dgd_err_cnt),
        .ram_dgd_err   (ram_dgd_err)
    );

    tb_ram_dgd_checker u_checker (
        .clk_wr        (clk_wr),
        .rst_wr_n      (rst_wr_n),
        .wr_beat       (wr_beat),
        .rd_beat       (rd_beat),
        .slink_prd_err (slink_prd_err),
        .dgd_err_cnt   (dgd_err_cnt),
        .ram_dgd_err   (ram_dgd_err),
        .error_count   (checker_errors),
        .checks_done   (checks_done)
    );

    always #(CLK_PERIOD / 2) clk_wr = ~clk_wr;

    // ------------------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------------------
    // Random frame; a second sop at restart_at restarts the window
    task automatic build_frame(input int n_words, input int restart_at);
        frame_words.delete();
        frame_sops.delete();
        for (int i = 0; i < n_words; i++) begin
            frame_words.push_back(rdg_pkg::data_word_t'($urandom));
            frame_sops.push_back(i == 0 || i == restart_at);
        end
        read_words = frame_words;
    endtask

    task automatic drive_beats(input bit rd_side, input bit use_gaps);
        rdg_pkg::word_beat_t b;
        int                  i;
        i = 0;
        while (i < frame_words.size()) begin
            @(negedge clk_wr);
            b      = '0;
            b.data = rdg_pkg::data_word_t'($urandom);
            if (!use_gaps || ($urandom % 4) != 0) begin
                b.val  = 1'b1;
                b.sop  = frame_sops[i];
                b.data = rd_side ? read_words[i] : frame_words[i];
                i++;
            end
            if (rd_side) rd_beat = b;
            else         wr_beat = b;
        end
        @(negedge clk_wr);
        wr_beat = '0;
        rd_beat = '0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk_wr);
    endtask

    task automatic wait_checked(input int target);
        int n;
        n = 0;
        while (checks_done < target && n < GAP_CYCLES) begin
            @(negedge clk_wr);
            n++;
        end
        if (checks_done < target) begin
            tb_errors++;
            $display("Checker reported no result for read frame %0d", target);
        end
    endtask

    // Write a frame, read it back with an optional single bit flip
    task automatic run_frame(input int n_words, input int restart_at, input int flip_idx,
                             input bit link_err);
        int bit_no;
        build_frame(n_words, restart_at);
        if (flip_idx >= 0) begin
            bit_no               = int'($urandom % `RDG_DATA_W);
            read_words[flip_idx] = read_words[flip_idx] ^ (16'h0001 << bit_no);
        end
        drive_beats(1'b0, 1'b1);
        idle_cycles(GAP_CYCLES);
        slink_prd_err = link_err;
        drive_beats(1'b1, 1'b1);
        frames_read++;
        wait_checked(frames_read);
        @(negedge clk_wr);
        slink_prd_err = 1'b0;
        idle_cycles(4);
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        int total;
        void'($urandom(SEED));
        clk_wr        = 1'b0;
        rst_wr_n      = 1'b0;
        wr_beat       = '0;
        rd_beat       = '0;
        slink_prd_err = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk_wr);
        rst_wr_n = 1'b1;
        idle_cycles(5);

        // Clean frames with val gaps
        repeat (4) run_frame(56, 0, -1, 1'b0);
        // One bit flip inside the window, then the same under link error
        run_frame(56, 0, int'($urandom % `RDG_CRC_WORDS), 1'b0);
        run_frame(56, 0, int'($urandom % `RDG_CRC_WORDS), 1'b1);
        // Long frame, flip beyond the window
        run_frame(64, 0, `RDG_CRC_WORDS + int'($urandom % 8), 1'b0);
        // Restart at word 10, flip only in the abandoned prefix
        run_frame(66, 10, int'($urandom % 10), 1'b0);
        // Drive the count into saturation
        repeat (6) run_frame(56, 0, int'($urandom % `RDG_CRC_WORDS), 1'b0);
        // Flag must hold through clean frames
        repeat (2) run_frame(56, 0, -1, 1'b0);

        idle_cycles(5);
        if (checks_done != NUM_FRAMES) begin
            tb_errors++;
            $display("Checker finished %0d frame checks, %0d were expected",
                     checks_done, NUM_FRAMES);
        end
        total = checker_errors + tb_errors;
        $display("Errors: %0d (checker %0d, testbench %0d), frames checked %0d",
                 total, checker_errors, tb_errors, checks_done);
        if (total == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Watchdog sized from the frame count
    initial begin
        #(WDOG_CYCLES * CLK_PERIOD);
        tb_errors++;
        $display("Simulation timed out after %0d clock cycles", WDOG_CYCLES);
        $display("Errors: %0d (checker %0d, testbench %0d), frames checked %0d",
                 checker_errors + tb_errors, checker_errors, tb_errors, checks_done);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_ram_dgd_checker.sv
// Testbench checker for the RAM degradation monitor
// Captures write and read frames, models the expected mismatch count
// and compares it with the DUT outputs

`timescale 1ns/10ps
`default_nettype none

`include "rdg_defines.svh"

module tb_ram_dgd_checker (
    input  logic                clk_wr,
    input  logic                rst_wr_n,
    input  rdg_pkg::word_beat_t wr_beat,
    input  rdg_pkg::word_beat_t rd_beat,
    input  logic                slink_prd_err,
    input  rdg_pkg::err_cnt_t   dgd_err_cnt,
    input  logic                ram_dgd_err,
    output int                  error_count,
    output int                  checks_done
);

    rdg_pkg::data_word_t wr_cap [`RDG_CRC_WORDS];
    rdg_pkg::data_word_t rd_cap [`RDG_CRC_WORDS];
    int                  wr_n          = 0;
    int                  rd_n          = 0;
    bit                  wr_active     = 1'b0;
    bit                  rd_active     = 1'b0;
    rdg_pkg::crc16_t     held_crc      = '0;
    rdg_pkg::crc16_t     rd_crc        = '0;
    int                  exp_cnt       = 0;
    logic                exp_flag;
    int                  frames_seen   = 0;
    longint              edge_no       = 0;
    longint              cnt_edge      = -1;
    longint              flag_edge     = -1;
    bit                  reset_checked = 1'b0;
    int                  errors        = 0;
    int                  checks        = 0;

    assign error_count = errors;
    assign checks_done = checks;

    // CRC-16/CCITT, poly 0x1021, seed all ones, MSB first, no final inversion
    function automatic rdg_pkg::crc16_t ref_crc(input rdg_pkg::data_word_t words [`RDG_CRC_WORDS]);
        rdg_pkg::crc16_t reg_q;
        logic            top_bit;
        reg_q = `RDG_CRC_SEED;
        for (int w = 0; w < `RDG_CRC_WORDS; w++) begin
            for (int b = `RDG_DATA_W - 1; b >= 0; b--) begin
                top_bit = reg_q[`RDG_CRC_W-1] ^ words[w][b];
                reg_q   = {reg_q[`RDG_CRC_W-2:0], 1'b0} ^ ({`RDG_CRC_W{top_bit}} & `RDG_CRC_POLY);
            end
        end
        return reg_q;
    endfunction

    // ------------------------------------------------------------------------
    // Frame capture and expected count
    // ------------------------------------------------------------------------
    always @(posedge clk_wr or negedge rst_wr_n) begin
        if (!rst_wr_n) begin
            wr_n      = 0;
            rd_n      = 0;
            wr_active = 1'b0;
            rd_active = 1'b0;
            exp_cnt   = 0;
            edge_no   = 0;
            cnt_edge  = -1;
            flag_edge = -1;
        end else begin
            edge_no++;
            // A sop restarts the window even in the middle of a frame
            if (wr_beat.val && (wr_beat.sop || wr_active)) begin
                if (wr_beat.sop) begin
                    wr_n = 0;
                end
                wr_cap[wr_n] = wr_beat.data;
                wr_n++;
                wr_active = 1'b1;
                if (wr_n == `RDG_CRC_WORDS) begin
                    held_crc  = ref_crc(wr_cap);
                    wr_active = 1'b0;
                    wr_n      = 0;
                end
            end
            if (rd_beat.val && (rd_beat.sop || rd_active)) begin
                if (rd_beat.sop) begin
                    rd_n = 0;
                end
                rd_cap[rd_n] = rd_beat.data;
                rd_n++;
                rd_active = 1'b1;
                if (rd_n == `RDG_CRC_WORDS) begin
                    rd_crc    = ref_crc(rd_cap);
                    rd_active = 1'b0;
                    rd_n      = 0;
                    if (rd_crc != held_crc && !slink_prd_err && exp_cnt < `RDG_ERR_LIMIT) begin
                        exp_cnt++;
                    end
                    frames_seen++;
                    cnt_edge  = edge_no + 2;
                    flag_edge = edge_no + 3;
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Output compare on the falling edge
    // ------------------------------------------------------------------------
    always @(negedge clk_wr) begin
        if (rst_wr_n) begin
            if (!reset_checked) begin
                reset_checked = 1'b1;
                if (dgd_err_cnt !== '0 || ram_dgd_err !== 1'b0) begin
                    errors++;
                    $display("[FAIL] t=%0t: after reset cnt=%0d flag=%b, expected 0 and 0",
                             $time, dgd_err_cnt, ram_dgd_err);
                end
            end
            if (edge_no == cnt_edge) begin
                if (dgd_err_cnt !== rdg_pkg::err_cnt_t'(exp_cnt)) begin
                    errors++;
                    $display("[FAIL] t=%0t: dgd_err_cnt=%0d, expected %0d after read frame %0d",
                             $time, dgd_err_cnt, exp_cnt, frames_seen);
                end
            end
            if (edge_no == flag_edge) begin
                exp_flag = (exp_cnt == `RDG_ERR_LIMIT);
                if (ram_dgd_err !== exp_flag) begin
                    errors++;
                    $display("[FAIL] t=%0t: ram_dgd_err=%b, expected %b after read frame %0d",
                             $time, ram_dgd_err, exp_flag, frames_seen);
                end
                checks++;
            end
        end
    end

endmodule

`default_nettype wire
